/* rtl/cfb_dec_pipe.sv */
`timescale 1ns/1ps

module cfb_dec_pipe
  import des_types_pkg::*;
  import des_tables_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  logic    in_valid,
  input  cfb_in_t in_blk,
  input  block_t  key,
  output logic    out_valid,
  output block_t  out_text
);

  subkey_arr_t  subkeys;
  round_state_t stage [num_rounds+1];  // stage 0 is the unregistered input
  block_t       ip_iv;
  block_t       keystream;

  // subkeys follow the key directly, so it must hold while blocks are in flight
  des_key_schedule i_key_schedule (
    .key     (key),
    .subkeys (subkeys)
  );

  assign ip_iv = permute_ip(in_blk.iv);

  assign stage[0] = '{
    valid:  in_valid,
    left:   ip_iv[block_w-1 -: half_w],
    right:  ip_iv[half_w-1:0],
    cipher: in_blk.cipher
  };

  // one Feistel round per clock, forward subkey order
  for (genvar k = 1; k <= num_rounds; k++)
  begin : g_round
    des_round_stage i_round_stage (
      .clk    (clk),
      .arst_n (arst_n),
      .subkey (subkeys[k-1]),
      .prev   (stage[k-1]),
      .next   (stage[k])
    );
  end

  // halves swap after the last round
  assign keystream = permute_ip_inv({stage[num_rounds].right, stage[num_rounds].left});

  assign out_text  = keystream ^ stage[num_rounds].cipher;
  assign out_valid = stage[num_rounds].valid;

endmodule

/* rtl/des_feistel_f.sv */
`timescale 1ns/1ps

module des_feistel_f
  import des_types_pkg::*;
  import des_tables_pkg::*;
(
  input  half_t   r_in,
  input  subkey_t subkey,
  output half_t   f_out
);

  subkey_t mixed;
  half_t   sbox_out;

  assign mixed = expand_e(r_in) ^ subkey;

  always_comb
  begin
    logic [sbox_in_w-1:0] grp;
    logic [1:0]           row;
    logic [3:0]           col;

    // group 0 sits in the top six bits and feeds S1
    for (int b = 0; b < sbox_num; b++)
    begin
      grp = mixed[subkey_w-1-sbox_in_w*b -: sbox_in_w];
      row = {grp[sbox_in_w-1], grp[0]};  // outer bits
      col = grp[sbox_in_w-2:1];
      sbox_out[half_w-1-sbox_out_w*b -: sbox_out_w] = sbox_out_w'(sbox_tbl[b][row][col]);
    end
  end

  assign f_out = permute_p(sbox_out);

endmodule

/* rtl/des_key_schedule.sv */
`timescale 1ns/1ps

module des_key_schedule
  import des_types_pkg::*;
  import des_tables_pkg::*;
(
  input  block_t      key,
  output subkey_arr_t subkeys
);

  localparam int cd_w = 2 * key_half_w;

  logic [cd_w-1:0] pc1_out;

  // pc-1 drops the parity bits and splits the key into C and D
  always_comb
  begin
    for (int i = 0; i < cd_w; i++)
      pc1_out[cd_w-1-i] = key[block_w-pc1_tbl[i]];
  end

  always_comb
  begin
    logic [key_half_w-1:0] c;
    logic [key_half_w-1:0] d;
    logic [cd_w-1:0]       cd;

    c = pc1_out[cd_w-1 -: key_half_w];
    d = pc1_out[key_half_w-1:0];
    for (int r = 0; r < num_rounds; r++)
    begin
      // rotations accumulate from round to round
      for (int s = 0; s < shift_tbl[r]; s++)
      begin
        c = {c[key_half_w-2:0], c[key_half_w-1]};
        d = {d[key_half_w-2:0], d[key_half_w-1]};
      end
      cd = {c, d};
      for (int i = 0; i < subkey_w; i++)
        subkeys[r][subkey_w-1-i] = cd[cd_w-pc2_tbl[i]];  // pc-2
    end
  end

endmodule

/* rtl/des_round_stage.sv */
`timescale 1ns/1ps

module des_round_stage
  import des_types_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  input  subkey_t      subkey,
  input  round_state_t prev,
  output round_state_t next
);

  half_t  f_val;
  logic   valid_q;
  half_t  left_q;
  half_t  right_q;
  block_t cipher_q;

  des_feistel_f i_feistel_f (
    .r_in   (prev.right),
    .subkey (subkey),
    .f_out  (f_val)
  );

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      valid_q <= 1'b0;
    else
      valid_q <= prev.valid;
  end

  always_ff @(posedge clk)
  begin
    left_q   <= prev.right;
    right_q  <= prev.left ^ f_val;
    cipher_q <= prev.cipher;
  end

  assign next = '{valid: valid_q, left: left_q, right: right_q, cipher: cipher_q};

endmodule

/* rtl/des_tables_pkg.sv */
package des_tables_pkg;
  import des_types_pkg::*;

  // all permutation tables are one-based, bit 1 is the msb
  localparam int ip_tbl [64] = '{
    58, 50, 42, 34, 26, 18, 10, 2,  60, 52, 44, 36, 28, 20, 12, 4,
    62, 54, 46, 38, 30, 22, 14, 6,  64, 56, 48, 40, 32, 24, 16, 8,
    57, 49, 41, 33, 25, 17, 9,  1,  59, 51, 43, 35, 27, 19, 11, 3,
    61, 53, 45, 37, 29, 21, 13, 5,  63, 55, 47, 39, 31, 23, 15, 7};

  localparam int ip_inv_tbl [64] = '{
    40, 8, 48, 16, 56, 24, 64, 32,  39, 7, 47, 15, 55, 23, 63, 31,
    38, 6, 46, 14, 54, 22, 62, 30,  37, 5, 45, 13, 53, 21, 61, 29,
    36, 4, 44, 12, 52, 20, 60, 28,  35, 3, 43, 11, 51, 19, 59, 27,
    34, 2, 42, 10, 50, 18, 58, 26,  33, 1, 41, 9,  49, 17, 57, 25};

  localparam int e_tbl [48] = '{
    32, 1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
    8,  9,  10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
    16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
    24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1};

  localparam int p_tbl [32] = '{
    16, 7,  20, 21, 29, 12, 28, 17,  1,  15, 23, 26, 5,  18, 31, 10,
    2,  8,  24, 14, 32, 27, 3,  9,   19, 13, 30, 6,  22, 11, 4,  25};

  localparam int pc1_tbl [56] = '{
    57, 49, 41, 33, 25, 17, 9,  1,  58, 50, 42, 34, 26, 18,
    10, 2,  59, 51, 43, 35, 27, 19, 11, 3,  60, 52, 44, 36,
    63, 55, 47, 39, 31, 23, 15, 7,  62, 54, 46, 38, 30, 22,
    14, 6,  61, 53, 45, 37, 29, 21, 13, 5,  28, 20, 12, 4};

  localparam int pc2_tbl [48] = '{
    14, 17, 11, 24, 1,  5,  3,  28, 15, 6,  21, 10,
    23, 19, 12, 4,  26, 8,  16, 7,  27, 20, 13, 2,
    41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
    44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32};

  // left rotation per round
  localparam int shift_tbl [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

  // [box][row][column]
  localparam int sbox_tbl [8][4][16] = '{
    '{'{14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7},
      '{0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8},
      '{4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0},
      '{15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13}},
    '{'{15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10},
      '{3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5},
      '{0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15},
      '{13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9}},
    '{'{10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8},
      '{13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1},
      '{13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7},
      '{1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12}},
    '{'{7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15},
      '{13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9},
      '{10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4},
      '{3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14}},
    '{'{2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9},
      '{14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6},
      '{4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14},
      '{11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3}},
    '{'{12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11},
      '{10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8},
      '{9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6},
      '{4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13}},
    '{'{4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1},
      '{13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6},
      '{1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2},
      '{6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12}},
    '{'{13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7},
      '{1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2},
      '{7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8},
      '{2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11}}};

  function automatic block_t permute_ip(block_t din);
    block_t dout;
    for (int i = 0; i < block_w; i++)
      dout[block_w-1-i] = din[block_w-ip_tbl[i]];
    return dout;
  endfunction

  function automatic block_t permute_ip_inv(block_t din);
    block_t dout;
    for (int i = 0; i < block_w; i++)
      dout[block_w-1-i] = din[block_w-ip_inv_tbl[i]];
    return dout;
  endfunction

  // 32 -> 48, edge bits of each nibble are duplicated
  function automatic subkey_t expand_e(half_t din);
    subkey_t dout;
    for (int i = 0; i < subkey_w; i++)
      dout[subkey_w-1-i] = din[half_w-e_tbl[i]];
    return dout;
  endfunction

  function automatic half_t permute_p(half_t din);
    half_t dout;
    for (int i = 0; i < half_w; i++)
      dout[half_w-1-i] = din[half_w-p_tbl[i]];
    return dout;
  endfunction

endpackage

/* rtl/des_types_pkg.sv */
package des_types_pkg;

  // DES widths, fixed by the standard
  localparam int block_w    = 64;
  localparam int half_w     = 32;
  localparam int subkey_w   = 48;
  localparam int num_rounds = 16;

  localparam int key_half_w = 28;  // C and D registers of the key schedule
  localparam int sbox_num   = 8;
  localparam int sbox_in_w  = 6;
  localparam int sbox_out_w = 4;

  typedef logic [block_w-1:0]  block_t;
  typedef logic [half_w-1:0]   half_t;
  typedef logic [subkey_w-1:0] subkey_t;

  // index 0 holds the round 1 subkey
  typedef subkey_t [num_rounds-1:0] subkey_arr_t;

  // top-level input bundle
  typedef struct packed
  {
    block_t cipher;
    block_t iv;
  } cfb_in_t;

  // state handed from one round stage to the next
  typedef struct packed
  {
    logic   valid;
    half_t  left;
    half_t  right;
    block_t cipher;  // rides along for the final xor
  } round_state_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -j 0 \
  --top-module tb_cfb_dec \
  -o Vtb_cfb_dec \
  -f sim.f

# the simulator exits non-zero on a failure, the grep below decides the result
sim_out="$(./obj_dir/Vtb_cfb_dec 2>&1)" || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "test passed"; then
  exit 0
else
  echo "simulation did not pass"
  exit 1
fi

/* sim.f */
rtl/des_types_pkg.sv
rtl/des_tables_pkg.sv
rtl/des_key_schedule.sv
rtl/des_feistel_f.sv
rtl/des_round_stage.sv
rtl/cfb_dec_pipe.sv
tb/tb_cfb_dec.sv

/* tb/tb_cfb_dec.sv */
`timescale 1ns/1ps

module tb_cfb_dec
  import des_types_pkg::*;
();

  localparam int clk_period   = 20;
  localparam int reset_cycles = 10;
  localparam int latency      = 16;

  // known answers from the DES validation vectors
  localparam block_t key1   = 64'h133457799BBCDFF1;
  localparam block_t iv1    = 64'h0123456789ABCDEF;
  localparam block_t ks1    = 64'h85E813540F0AB405;
  localparam block_t key1_n = 64'hECCBA8866443200E;  // complemented key, iv and keystream
  localparam block_t iv1_n  = 64'hFEDCBA9876543210;
  localparam block_t ks1_n  = 64'h7A17ECABF0F54BFA;
  localparam block_t key2   = 64'h0E329232EA6D0D73;
  localparam block_t iv2    = 64'h8787878787878787;
  localparam block_t ks2    = 64'h0000000000000000;

  localparam int kat1_n   = 4;
  localparam int kat2_n   = 6;
  localparam int stream_n = 40;
  localparam int gap_n    = 12;
  localparam int max_gap  = 20;
  localparam int flush_n  = 5;
  localparam int idle_n   = 20;
  localparam int drains   = 6;

  localparam int total_blocks = 2 * kat1_n + kat2_n + 2 * stream_n + gap_n + flush_n;
  localparam int run_cycles   = total_blocks + gap_n * max_gap + drains * (latency + 2)
                                + 2 * reset_cycles + idle_n + 8;
  localparam int timeout_ns   = 2 * run_cycles * clk_period;

  logic    clk;
  logic    arst_n;
  logic    in_valid;
  cfb_in_t in_blk;
  block_t  key;
  logic    out_valid;
  block_t  out_text;

  int     cycle_cnt;
  int     out_cnt;
  block_t exp_q [$];
  int     edge_q [$];  // cycle in which each block was driven

  cfb_dec_pipe i_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_blk    (in_blk),
    .key       (key),
    .out_valid (out_valid),
    .out_text  (out_text)
  );

  always #(clk_period / 2) clk = ~clk;

  always @(posedge clk)
    cycle_cnt <= cycle_cnt + 1;

  task automatic report_failure(input string what);
    $display("error at %0t ns: %s", $time, what);
    $display("test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected)
    begin
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, expected);
      $display("test failed");
      $fatal(1, "simulation stopped");
    end
  endtask

  // outputs settle after the rising edge, so look at them on the falling one
  always @(negedge clk)
  begin
    block_t exp_text;
    int     acc_edge;

    if (!arst_n)
    begin
      if (out_valid !== 1'b0)
        report_failure("out_valid is not low while reset is asserted");
    end
    else if (out_valid === 1'b1)
    begin
      if (exp_q.size() == 0)
        report_failure("out_valid pulsed with no block outstanding");
      exp_text = exp_q.pop_front();
      acc_edge = edge_q.pop_front();
      out_cnt++;
      check_value("out_text", out_text, exp_text);
      check_value("latency in cycles", 64'(cycle_cnt - acc_edge), 64'(latency));
    end
    else if (out_valid !== 1'b0)
      report_failure("out_valid is unknown after reset");
  end

  function automatic block_t rand_block();
    return {$urandom, $urandom};
  endfunction

  // called at 2 ns past a rising edge, returns at the same point of the next cycle
  task automatic send_block(input block_t iv, input block_t cipher, input block_t expected);
    in_valid      = 1'b1;
    in_blk.iv     = iv;
    in_blk.cipher = cipher;
    exp_q.push_back(expected);
    edge_q.push_back(cycle_cnt);
    @(posedge clk);
    #2;
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0)
      @(posedge clk);
    #2;
  endtask

  task automatic key1_known_answer();
    block_t c;
    key = key1;
    send_block(iv1, '0, ks1);
    for (int i = 1; i < kat1_n; i++)
    begin
      c = rand_block();
      send_block(iv1, c, c ^ ks1);
    end
    wait_drain();
  endtask

  task automatic key2_known_answer();
    block_t c;
    key = key2;
    for (int i = 0; i < kat2_n; i++)
    begin
      c = rand_block();
      send_block(iv2, c, c ^ ks2);  // keystream is zero so plaintext equals cipher
    end
    wait_drain();
  endtask

  // key holds for the whole stream
  task automatic stream_blocks(input block_t k, input block_t iv, input block_t ks);
    block_t c;
    int     start_cnt;
    key       = k;
    start_cnt = out_cnt;
    for (int i = 0; i < stream_n; i++)
    begin
      c = rand_block();
      send_block(iv, c, c ^ ks);
    end
    // the last block is out one latency after it was sent
    repeat (latency) @(posedge clk);
    #2;
    check_value("streamed output count", 64'(out_cnt - start_cnt), 64'(stream_n));
  endtask

  task automatic back_to_back_stream();
    stream_blocks(key1, iv1, ks1);
    stream_blocks(key1_n, iv1_n, ks1_n);
  endtask

  task automatic gapped_latency();
    block_t c;
    int     gap;
    key = key1;
    for (int i = 0; i < gap_n; i++)
    begin
      c = rand_block();
      send_block(iv1, c, c ^ ks1);
      gap = $urandom_range(max_gap, 0);
      if (gap > 0)
      begin
        repeat (gap) @(posedge clk);
        #2;
      end
    end
    wait_drain();
  endtask

  task automatic reset_flush();
    key = key1;
    for (int i = 0; i < flush_n; i++)
      send_block(iv1, rand_block(), '0);
    repeat (4) @(posedge clk);
    #2;
    arst_n = 1'b0;  // blocks still in the pipe are dropped
    exp_q.delete();
    edge_q.delete();
    repeat (reset_cycles) @(posedge clk);
    #2;
    arst_n = 1'b1;
    repeat (idle_n) @(posedge clk);
    #2;
    key1_known_answer();
  endtask

  initial
  begin
    #(timeout_ns);
    $display("timeout: the tests did not finish within %0d ns", timeout_ns);
    $display("test failed");
    $fatal(1, "simulation stopped");
  end

  initial
  begin
    void'($urandom(32'hcd8d));
    clk       = 1'b0;
    arst_n    = 1'b0;
    in_valid  = 1'b0;
    in_blk    = '0;
    key       = '0;
    cycle_cnt = 0;
    out_cnt   = 0;

    repeat (reset_cycles) @(posedge clk);
    #2;
    arst_n = 1'b1;
    @(posedge clk);
    #2;

    key1_known_answer();
    key2_known_answer();
    back_to_back_stream();
    gapped_latency();
    reset_flush();

    $display("test passed");
    $finish;
  end

endmodule
